// ==== csr_exec.f ====
+incdir+source
source/csr_exec_pkg.sv
source/csr_decoder.sv
source/csr_exec_unit.sv
source/csr_file.sv
source/csr_exec_top.sv
testbench/csr_exec_assertions.sv
testbench/csr_exec_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the CSR datapath testbench with Verilator and run it
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module csr_exec_tb -f csr_exec.f -o csr_exec_sim

# a failing assertion stops the binary with a non-zero status
./obj_dir/csr_exec_sim 2>&1 | tee "$LOG"

if grep -q "Simulation failed" "$LOG"; then
    echo "csr_exec: testbench reported errors, see $LOG"
    exit 1
fi

echo "csr_exec: run finished cleanly"

// ==== source/csr_decoder.sv ====
/*
 * decode stage for the Zicsr instructions
 * picks op, operand, CSR address and the write intents
 */
`timescale 1ns/1ps
`default_nettype none

`include "csr_exec_params.svh"

module csr_decoder (
    input  wire                            instr_valid_i,
    input  wire  [`XLEN-1:0]               instr_i,
    input  wire  [`XLEN-1:0]               rs1_data_i,
    output csr_exec_pkg::csr_op_e          csr_op_o,
    output logic [`XLEN-1:0]               csr_operand_o,
    output csr_exec_pkg::csr_addr_t        csr_addr_o,
    output logic                           csr_we_req_o,  // CSR gets written
    output logic                           rd_we_req_o,   // rd gets the old value
    output logic [`REG_ADDR_WIDTH-1:0]     rd_addr_o
);
    import csr_exec_pkg::*;

    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    logic [6:0]                 opcode;
    logic [2:0]                 funct3;
    logic [4:0]                 rs1_uimm;   // rs1 index or uimm, same field
    logic [`REG_ADDR_WIDTH-1:0] rd_idx;
    logic                       is_imm;
    logic                       src_nonzero;

    // instruction fields
    assign opcode   = instr_i[6:0];
    assign rd_idx   = instr_i[11:7];
    assign funct3   = instr_i[14:12];
    assign rs1_uimm = instr_i[19:15];

    assign is_imm      = funct3[2];          // csrr*i forms
    assign src_nonzero = (rs1_uimm != 5'd0);

    // op select, funct3 000 is ecall/ebreak space and 100 is reserved
    always_comb begin
        csr_op_o = CSR_OP_NONE;
        if (instr_valid_i && (opcode == OPC_SYSTEM)) begin
            case (funct3[1:0])
                2'b01:   csr_op_o = CSR_OP_RW;
                2'b10:   csr_op_o = CSR_OP_RS;
                2'b11:   csr_op_o = CSR_OP_RC;
                default: csr_op_o = CSR_OP_NONE;
            endcase
        end
    end

    // register operand or zero-extended uimm
    assign csr_operand_o = is_imm ? {{(`XLEN-5){1'b0}}, rs1_uimm} : rs1_data_i;

    assign csr_addr_o = instr_i[31:20];
    assign rd_addr_o  = rd_idx;

    // set/clear with x0 or uimm 0 only reads the CSR
    always_comb begin
        case (csr_op_o)
            CSR_OP_RW: csr_we_req_o = 1'b1;
            CSR_OP_RS: csr_we_req_o = src_nonzero;
            CSR_OP_RC: csr_we_req_o = src_nonzero;
            default:   csr_we_req_o = 1'b0;
        endcase
    end

    // x0 as rd discards the old value
    assign rd_we_req_o = (csr_op_o != CSR_OP_NONE) && (rd_idx != '0);

endmodule

`default_nettype wire

// ==== source/csr_exec_params.svh ====
/*
 * widths for data, rd index, commit tag and CSR address
 * the six machine-mode CSR addresses
 * write masks for the implemented CSRs
 */
`ifndef CSR_EXEC_PARAMS_SVH
`define CSR_EXEC_PARAMS_SVH

// datapath widths
`define XLEN            32
`define REG_ADDR_WIDTH  5   // rd index
`define COMMIT_ID_WIDTH 4
`define CSR_ADDR_WIDTH  12

// implemented machine-mode CSRs
`define CSR_MSTATUS     12'h300
`define CSR_MIE         12'h304
`define CSR_MTVEC       12'h305
`define CSR_MSCRATCH    12'h340
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342

// writable bits per CSR, everything else reads 0
`define CSR_MSTATUS_WMASK 32'h0000_0088 // MIE (3) and MPIE (7) only
`define CSR_MTVEC_WMASK   32'hFFFF_FFFC // base aligned, mode bits tied low
`define CSR_MEPC_WMASK    32'hFFFF_FFFE // bit 0 always zero
`define CSR_FULL_WMASK    32'hFFFF_FFFF // mie, mscratch, mcause

`endif

// ==== source/csr_exec_pkg.sv ====
/*
 * shared types of the CSR datapath
 * CSR operation encoding and CSR address type
 */
`default_nettype none

`include "csr_exec_params.svh"

package csr_exec_pkg;

    // operation after decode, immediate forms fold into the same three
    typedef enum logic [1:0] {
        CSR_OP_NONE = 2'd0, // not a CSR instruction
        CSR_OP_RW   = 2'd1, // csrrw / csrrwi
        CSR_OP_RS   = 2'd2, // csrrs / csrrsi
        CSR_OP_RC   = 2'd3  // csrrc / csrrci
    } csr_op_e;

    // 12-bit CSR address from instr[31:20]
    typedef logic [`CSR_ADDR_WIDTH-1:0] csr_addr_t;

endpackage

`default_nettype wire

// ==== source/csr_exec_top.sv ====
/*
 * CSR datapath top
 * decoder, execute unit and CSR file
 */
`timescale 1ns/1ps
`default_nettype none

`include "csr_exec_params.svh"

module csr_exec_top (
    input  wire                          clk,
    input  wire                          rst_n_i,
    input  wire                          instr_valid_i,
    input  wire  [`XLEN-1:0]             instr_i,
    input  wire  [`XLEN-1:0]             rs1_data_i,
    input  wire  [`COMMIT_ID_WIDTH-1:0]  commit_id_i,
    input  wire                          int_assert_i,
    input  wire                          wb_ready_i,
    output logic                         rd_we_o,
    output logic [`REG_ADDR_WIDTH-1:0]   rd_addr_o,
    output logic [`XLEN-1:0]             rd_wdata_o,
    output logic [`COMMIT_ID_WIDTH-1:0]  commit_id_o,
    output logic                         csr_stall_o,
    output logic                         csr_we_o,    // committed CSR write
    output csr_exec_pkg::csr_addr_t      csr_waddr_o,
    output logic [`XLEN-1:0]             csr_wdata_o
);
    import csr_exec_pkg::*;

    csr_op_e                    csr_op;
    logic [`XLEN-1:0]           csr_operand;
    csr_addr_t                  csr_addr;     // to execute and the read port
    logic                       csr_we_req;
    logic                       rd_we_req;
    logic [`REG_ADDR_WIDTH-1:0] dec_rd_addr;
    logic [`XLEN-1:0]           csr_rdata;    // combinational, forwarded

    csr_decoder u_csr_decoder (
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_data_i    (rs1_data_i),
        .csr_op_o      (csr_op),
        .csr_operand_o (csr_operand),
        .csr_addr_o    (csr_addr),
        .csr_we_req_o  (csr_we_req),
        .rd_we_req_o   (rd_we_req),
        .rd_addr_o     (dec_rd_addr)
    );

    csr_exec_unit u_csr_exec_unit (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .csr_op_i      (csr_op),
        .csr_operand_i (csr_operand),
        .csr_addr_i    (csr_addr),
        .csr_rdata_i   (csr_rdata),
        .csr_we_req_i  (csr_we_req),
        .rd_we_req_i   (rd_we_req),
        .rd_addr_i     (dec_rd_addr),
        .commit_id_i   (commit_id_i),
        .int_assert_i  (int_assert_i),
        .wb_ready_i    (wb_ready_i),
        .csr_stall_o   (csr_stall_o),
        .csr_we_o      (csr_we_o),
        .csr_waddr_o   (csr_waddr_o),
        .csr_wdata_o   (csr_wdata_o),
        .rd_we_o       (rd_we_o),
        .rd_addr_o     (rd_addr_o),
        .rd_wdata_o    (rd_wdata_o),
        .commit_id_o   (commit_id_o)
    );

    // write port fed back from the execute registers
    csr_file u_csr_file (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .raddr_i (csr_addr),
        .rdata_o (csr_rdata),
        .we_i    (csr_we_o),
        .waddr_i (csr_waddr_o),
        .wdata_i (csr_wdata_o)
    );

endmodule

`default_nettype wire

// ==== source/csr_exec_unit.sv ====
/*
 * execute stage of the CSR datapath
 * write/set/clear value, old value to rd, interrupt cancel
 * result registers loaded while wb_ready_i is high
 */
`timescale 1ns/1ps
`default_nettype none

`include "csr_exec_params.svh"

module csr_exec_unit (
    input  wire                              clk,
    input  wire                              rst_n_i,
    // from decode
    input  wire csr_exec_pkg::csr_op_e       csr_op_i,
    input  wire  [`XLEN-1:0]                 csr_operand_i,
    input  wire csr_exec_pkg::csr_addr_t     csr_addr_i,
    input  wire  [`XLEN-1:0]                 csr_rdata_i,   // current CSR value, forwarded
    input  wire                              csr_we_req_i,
    input  wire                              rd_we_req_i,
    input  wire  [`REG_ADDR_WIDTH-1:0]       rd_addr_i,
    input  wire  [`COMMIT_ID_WIDTH-1:0]      commit_id_i,
    input  wire                              int_assert_i,  // pending interrupt level
    input  wire                              wb_ready_i,    // writeback takes results
    output logic                             csr_stall_o,
    // committed CSR write
    output logic                             csr_we_o,
    output csr_exec_pkg::csr_addr_t          csr_waddr_o,
    output logic [`XLEN-1:0]                 csr_wdata_o,
    // rd writeback
    output logic                             rd_we_o,
    output logic [`REG_ADDR_WIDTH-1:0]       rd_addr_o,
    output logic [`XLEN-1:0]                 rd_wdata_o,
    output logic [`COMMIT_ID_WIDTH-1:0]      commit_id_o
);
    import csr_exec_pkg::*;

    logic             op_valid;      // real CSR op, not cancelled
    logic             is_rw;
    logic             is_rs;
    logic             is_rc;
    logic [`XLEN-1:0] csr_wdata_nxt;
    logic [`XLEN-1:0] rd_wdata_nxt;
    logic             csr_we_nxt;
    logic             rd_we_nxt;

    // an interrupt simply drops the CSR op
    assign op_valid = (csr_op_i != CSR_OP_NONE) && !int_assert_i;

    assign is_rw = (csr_op_i == CSR_OP_RW);
    assign is_rs = (csr_op_i == CSR_OP_RS);
    assign is_rc = (csr_op_i == CSR_OP_RC);

    always_comb begin
        csr_wdata_nxt = '0;
        rd_wdata_nxt  = '0;
        if (op_valid) begin
            rd_wdata_nxt  = csr_rdata_i; // every form returns the old value
            // one-hot and-or select of the new value
            csr_wdata_nxt = ({`XLEN{is_rw}} & csr_operand_i)
                          | ({`XLEN{is_rs}} & (csr_rdata_i | csr_operand_i))
                          | ({`XLEN{is_rc}} & (csr_rdata_i & ~csr_operand_i));
        end
    end

    assign csr_we_nxt = op_valid && csr_we_req_i;
    assign rd_we_nxt  = op_valid && rd_we_req_i;

    // write enables, held while writeback is busy
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            csr_we_o <= 1'b0;
            rd_we_o  <= 1'b0;
        end else if (wb_ready_i) begin
            csr_we_o <= csr_we_nxt;
            rd_we_o  <= rd_we_nxt;
        end
    end

    // result payload, same load enable
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            csr_waddr_o <= '0;
            csr_wdata_o <= '0;
            rd_addr_o   <= '0;
            rd_wdata_o  <= '0;
            commit_id_o <= '0;
        end else if (wb_ready_i) begin
            csr_waddr_o <= csr_addr_i;
            csr_wdata_o <= csr_wdata_nxt;
            rd_addr_o   <= rd_addr_i;
            rd_wdata_o  <= rd_wdata_nxt;
            commit_id_o <= commit_id_i;
        end
    end

    // held CSR write not yet taken by writeback
    assign csr_stall_o = csr_we_o & ~wb_ready_i;

endmodule

`default_nettype wire

// ==== source/csr_file.sv ====
/*
 * machine-mode CSR file, six registers with write masks
 * combinational read port with write forwarding
 */
`timescale 1ns/1ps
`default_nettype none

`include "csr_exec_params.svh"

module csr_file (
    input  wire                          clk,
    input  wire                          rst_n_i,
    input  wire csr_exec_pkg::csr_addr_t raddr_i,
    output logic [`XLEN-1:0]             rdata_o,
    input  wire                          we_i,     // registered write from execute
    input  wire csr_exec_pkg::csr_addr_t waddr_i,
    input  wire  [`XLEN-1:0]             wdata_i
);
    import csr_exec_pkg::*;

    logic [`XLEN-1:0] mstatus_q;
    logic [`XLEN-1:0] mie_q;
    logic [`XLEN-1:0] mtvec_q;
    logic [`XLEN-1:0] mscratch_q;
    logic [`XLEN-1:0] mepc_q;
    logic [`XLEN-1:0] mcause_q;

    logic [`XLEN-1:0] stored_rdata;
    logic [`XLEN-1:0] wdata_masked;
    logic             fwd_hit;

    // writable bits by address, zero for anything unimplemented
    function automatic logic [`XLEN-1:0] csr_wmask(input csr_addr_t addr);
        logic [`XLEN-1:0] mask;
        case (addr)
            `CSR_MSTATUS:  mask = `CSR_MSTATUS_WMASK;
            `CSR_MIE:      mask = `CSR_FULL_WMASK;
            `CSR_MTVEC:    mask = `CSR_MTVEC_WMASK;
            `CSR_MSCRATCH: mask = `CSR_FULL_WMASK;
            `CSR_MEPC:     mask = `CSR_MEPC_WMASK;
            `CSR_MCAUSE:   mask = `CSR_FULL_WMASK;
            default:       mask = '0;
        endcase
        return mask;
    endfunction

    assign wdata_masked = wdata_i & csr_wmask(waddr_i);

    // stored values are already masked
    always_comb begin
        case (raddr_i)
            `CSR_MSTATUS:  stored_rdata = mstatus_q;
            `CSR_MIE:      stored_rdata = mie_q;
            `CSR_MTVEC:    stored_rdata = mtvec_q;
            `CSR_MSCRATCH: stored_rdata = mscratch_q;
            `CSR_MEPC:     stored_rdata = mepc_q;
            `CSR_MCAUSE:   stored_rdata = mcause_q;
            default:       stored_rdata = '0;  // unimplemented reads zero
        endcase
    end

    // pending write to the same CSR wins, back-to-back ops see it
    assign fwd_hit = we_i && (waddr_i == raddr_i);
    assign rdata_o = fwd_hit ? wdata_masked : stored_rdata;

    // write port, a held write just rewrites the same value
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mstatus_q  <= '0;
            mie_q      <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
        end else if (we_i) begin
            case (waddr_i)
                `CSR_MSTATUS:  mstatus_q  <= wdata_masked;
                `CSR_MIE:      mie_q      <= wdata_masked;
                `CSR_MTVEC:    mtvec_q    <= wdata_masked;
                `CSR_MSCRATCH: mscratch_q <= wdata_masked;
                `CSR_MEPC:     mepc_q     <= wdata_masked;
                `CSR_MCAUSE:   mcause_q   <= wdata_masked;
                default: ;                 // writes to unimplemented CSRs dropped
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== testbench/csr_exec_assertions.sv ====
/*
 * concurrent checks on the execute unit, bound into csr_exec_unit
 * result hold under backpressure, stall level, interrupt cancel
 */
`timescale 1ns/1ps
`default_nettype none

`include "csr_exec_params.svh"

module csr_exec_assertions (
    input wire                           clk,
    input wire                           rst_n_i,
    input wire csr_exec_pkg::csr_op_e    csr_op_i,
    input wire                           csr_we_req_i,     // decoded CSR write request
    input wire                           int_assert_i,
    input wire                           wb_ready_i,
    input wire                           stall_i,          // csr_stall_o of the unit
    input wire                           res_csr_we_i,     // registered results
    input wire csr_exec_pkg::csr_addr_t  res_csr_waddr_i,
    input wire [`XLEN-1:0]               res_csr_wdata_i,
    input wire                           res_rd_we_i,
    input wire [`REG_ADDR_WIDTH-1:0]     res_rd_addr_i,
    input wire [`XLEN-1:0]               res_rd_wdata_i,
    input wire [`COMMIT_ID_WIDTH-1:0]    res_commit_id_i
);
    import csr_exec_pkg::*;

    logic held_csr_we;   // CSR write of the last accepted issue

    // accepted only on edges with writeback ready, interrupt drops it
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            held_csr_we <= 1'b0;
        end else if (wb_ready_i) begin
            held_csr_we <= csr_we_req_i && (csr_op_i != CSR_OP_NONE) && !int_assert_i;
        end
    end

    // no load while writeback is busy, so nothing may move
    hold_when_not_ready: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !wb_ready_i |=> $stable({res_csr_we_i, res_csr_waddr_i, res_csr_wdata_i,
                                 res_rd_we_i, res_rd_addr_i, res_rd_wdata_i,
                                 res_commit_id_i})
    ) else $error("execute results changed while wb_ready_i was low");

    // stall only while an accepted CSR write waits for writeback
    stall_only_when_blocked: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        stall_i |-> (!wb_ready_i && held_csr_we)
    ) else $error("csr_stall_o high without a blocked accepted CSR write");

    // interrupt at issue drops both writes
    no_write_after_cancel: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (wb_ready_i && int_assert_i && (csr_op_i != CSR_OP_NONE))
            |=> (!res_csr_we_i && !res_rd_we_i)
    ) else $error("write enable seen after an interrupt-cancelled CSR op");

endmodule

bind csr_exec_unit csr_exec_assertions u_csr_exec_assertions (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .csr_op_i        (csr_op_i),
    .csr_we_req_i    (csr_we_req_i),
    .int_assert_i    (int_assert_i),
    .wb_ready_i      (wb_ready_i),
    .stall_i         (csr_stall_o),
    .res_csr_we_i    (csr_we_o),
    .res_csr_waddr_i (csr_waddr_o),
    .res_csr_wdata_i (csr_wdata_o),
    .res_rd_we_i     (rd_we_o),
    .res_rd_addr_i   (rd_addr_o),
    .res_rd_wdata_i  (rd_wdata_o),
    .res_commit_id_i (commit_id_o)
);

`default_nettype wire

// ==== testbench/csr_exec_tb.sv ====
/*
 * testbench for the CSR datapath top
 * seeded random Zicsr stimulus against a CSR reference model
 * output checks, watchdog and final result
 */
`timescale 1ns/1ps
`default_nettype none

`include "csr_exec_params.svh"

module csr_exec_tb;

    localparam int         RESET_CYCLES    = 10;
    localparam int         DIRECTED_CYCLES = 6;    // one read per implemented CSR
    localparam int         RANDOM_CYCLES   = 2000;
    localparam int         CLK_PERIOD_NS   = 4;
    localparam int         TIMEOUT_NS      =
        (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 2) * CLK_PERIOD_NS + 400;
    localparam logic [6:0] OPC_SYSTEM      = 7'h73;

    logic                          clk = 1'b0;
    logic                          rst_n_i;
    logic                          instr_valid_i;
    logic [`XLEN-1:0]              instr_i;
    logic [`XLEN-1:0]              rs1_data_i;
    logic [`COMMIT_ID_WIDTH-1:0]   commit_id_i;
    logic                          int_assert_i;
    logic                          wb_ready_i;
    logic                          rd_we_o;
    logic [`REG_ADDR_WIDTH-1:0]    rd_addr_o;
    logic [`XLEN-1:0]              rd_wdata_o;
    logic [`COMMIT_ID_WIDTH-1:0]   commit_id_o;
    logic                          csr_stall_o;
    logic                          csr_we_o;
    logic [`CSR_ADDR_WIDTH-1:0]    csr_waddr_o;
    logic [`XLEN-1:0]              csr_wdata_o;

    // reference model state
    logic [`XLEN-1:0]              model_csr [0:7];   // index 7 unused
    logic                          exp_rd_we;
    logic                          exp_csr_we;
    logic [`REG_ADDR_WIDTH-1:0]    exp_rd_addr;
    logic [`XLEN-1:0]              exp_rd_wdata;
    logic [`XLEN-1:0]              exp_csr_wdata;
    logic [`CSR_ADDR_WIDTH-1:0]    exp_csr_waddr;
    logic [`COMMIT_ID_WIDTH-1:0]   exp_commit_id;

    integer                        seed;
    int                            errors;
    int                            checks;
    int                            cycle;
    logic [`CSR_ADDR_WIDTH-1:0]    last_addr;         // for back-to-back hits
    logic [`COMMIT_ID_WIDTH-1:0]   cid_next;

    always #(CLK_PERIOD_NS / 2) clk = ~clk;

    csr_exec_top u_csr_exec_top (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_data_i    (rs1_data_i),
        .commit_id_i   (commit_id_i),
        .int_assert_i  (int_assert_i),
        .wb_ready_i    (wb_ready_i),
        .rd_we_o       (rd_we_o),
        .rd_addr_o     (rd_addr_o),
        .rd_wdata_o    (rd_wdata_o),
        .commit_id_o   (commit_id_o),
        .csr_stall_o   (csr_stall_o),
        .csr_we_o      (csr_we_o),
        .csr_waddr_o   (csr_waddr_o),
        .csr_wdata_o   (csr_wdata_o)
    );

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    // 0..5 are the machine CSRs, 6 and 7 two unimplemented neighbours
    function automatic logic [`CSR_ADDR_WIDTH-1:0] pick_csr(input logic [2:0] sel);
        case (sel)
            3'd0:    return `CSR_MSTATUS;
            3'd1:    return `CSR_MIE;
            3'd2:    return `CSR_MTVEC;
            3'd3:    return `CSR_MSCRATCH;
            3'd4:    return `CSR_MEPC;
            3'd5:    return `CSR_MCAUSE;
            3'd6:    return 12'h301;
            default: return 12'h343;
        endcase
    endfunction

    function automatic logic [2:0] csr_index(input logic [`CSR_ADDR_WIDTH-1:0] addr);
        case (addr)
            `CSR_MSTATUS:  return 3'd0;
            `CSR_MIE:      return 3'd1;
            `CSR_MTVEC:    return 3'd2;
            `CSR_MSCRATCH: return 3'd3;
            `CSR_MEPC:     return 3'd4;
            `CSR_MCAUSE:   return 3'd5;
            default:       return 3'd7;   // not implemented
        endcase
    endfunction

    // bits that survive a write
    function automatic logic [31:0] csr_keep_bits(input logic [2:0] idx);
        case (idx)
            3'd0:    return 32'h0000_0088;  // mstatus MIE, MPIE
            3'd2:    return 32'hFFFF_FFFC;  // mtvec mode bits
            3'd4:    return 32'hFFFF_FFFE;  // mepc bit 0
            default: return 32'hFFFF_FFFF;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL time %0d ns: %s is %h, expected %h",
                     $time, name, actual, expected);
        end
    endtask

    // instruction on the inputs was accepted at this edge
    task automatic model_issue();
        logic [6:0]  opcode;
        logic [2:0]  f3;
        logic [4:0]  src;
        logic [4:0]  rd;
        logic [11:0] addr;
        logic [2:0]  idx;
        logic [31:0] operand;
        logic [31:0] old_val;
        logic [31:0] new_val;
        logic        is_csr;
        logic        writes;
        opcode  = instr_i[6:0];
        rd      = instr_i[11:7];
        f3      = instr_i[14:12];
        src     = instr_i[19:15];
        addr    = instr_i[31:20];
        idx     = csr_index(addr);
        operand = f3[2] ? {27'd0, src} : rs1_data_i;     // uimm zero-extended
        old_val = (idx == 3'd7) ? 32'd0 : model_csr[idx];
        is_csr  = instr_valid_i && (opcode == OPC_SYSTEM) && (f3[1:0] != 2'b00);
        case (f3[1:0])
            2'b01: begin
                new_val = operand;
                writes  = 1'b1;
            end
            2'b10: begin
                new_val = old_val | operand;
                writes  = (src != 5'd0);   // zero source is read only
            end
            default: begin
                new_val = old_val & ~operand;
                writes  = (src != 5'd0);
            end
        endcase
        exp_csr_waddr = addr;
        exp_rd_addr   = rd;
        exp_commit_id = commit_id_i;
        if (is_csr && !int_assert_i) begin
            exp_csr_we    = writes;
            exp_rd_we     = (rd != 5'd0);
            exp_rd_wdata  = old_val;
            exp_csr_wdata = new_val;
            if (writes && (idx != 3'd7))
                model_csr[idx] = new_val & csr_keep_bits(idx);
        end else begin
            exp_csr_we    = 1'b0;   // cancelled or no CSR op
            exp_rd_we     = 1'b0;
            exp_rd_wdata  = 32'd0;
            exp_csr_wdata = 32'd0;
        end
    endtask

    task automatic drive_inputs(input logic valid, input logic [31:0] instr,
                                input logic [31:0] rs1, input logic irq, input logic ready);
        instr_valid_i <= valid;
        instr_i       <= instr;
        rs1_data_i    <= rs1;
        commit_id_i   <= cid_next;
        int_assert_i  <= irq;
        wb_ready_i    <= ready;
        cid_next       = cid_next + 4'd1;
    endtask

    task automatic drive_random();
        logic [31:0] r_addr;
        logic [31:0] r_fields;
        logic [31:0] r_ctrl;
        logic [11:0] addr;
        logic [2:0]  f3;
        logic [4:0]  src;
        logic [4:0]  rd;
        logic [6:0]  opcode;
        r_addr   = next_rand();
        r_fields = next_rand();
        r_ctrl   = next_rand();
        if (r_addr[1:0] == 2'd0)
            addr = last_addr;               // same CSR again, hits forwarding
        else if (r_addr[4:2] == 3'd7)
            addr = r_addr[31:20];           // anywhere, mostly unimplemented
        else
            addr = pick_csr(r_addr[10:8]);
        if (r_fields[3:0] == 4'd0)
            f3 = r_fields[6:4];             // includes the non-CSR funct3 values
        else if (r_fields[5:4] == 2'd0)
            f3 = {r_fields[6], 2'b01};
        else
            f3 = r_fields[6:4];
        src    = (r_fields[9:8] == 2'd0) ? 5'd0 : r_fields[14:10];
        rd     = (r_fields[17:15] == 3'd0) ? 5'd0 : r_fields[22:18];
        opcode = (r_fields[27:24] == 4'd0) ? {r_fields[30:28], r_fields[23:20]} : OPC_SYSTEM;
        last_addr = addr;
        drive_inputs(r_ctrl[19:16] != 4'd0, {addr, src, f3, rd, opcode}, next_rand(),
                     (r_ctrl[31:16] % 16'd100) < 16'd5,
                     (r_ctrl[15:0] % 16'd100) >= 16'd20);
    endtask

    task automatic model_edge();
        @(posedge clk);
        if (wb_ready_i)
            model_issue();
    endtask

    task automatic check_outputs();
        logic exp_stall;
        if (wb_ready_i)
            exp_stall = 1'b0;            // writeback takes the result
        else
            exp_stall = exp_csr_we;      // held write blocks
        check_value("rd_we_o", 32'(rd_we_o), 32'(exp_rd_we));
        check_value("rd_addr_o", 32'(rd_addr_o), 32'(exp_rd_addr));
        check_value("rd_wdata_o", rd_wdata_o, exp_rd_wdata);
        check_value("commit_id_o", 32'(commit_id_o), 32'(exp_commit_id));
        check_value("csr_we_o", 32'(csr_we_o), 32'(exp_csr_we));
        check_value("csr_waddr_o", 32'(csr_waddr_o), 32'(exp_csr_waddr));
        check_value("csr_wdata_o", csr_wdata_o, exp_csr_wdata);
        check_value("csr_stall_o", 32'(csr_stall_o), 32'(exp_stall));
    endtask

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: run did not complete within %0d ns", TIMEOUT_NS);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        seed      = 32'h5801;
        errors    = 0;
        checks    = 0;
        last_addr = `CSR_MSCRATCH;
        cid_next  = 4'd0;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = 32'd0;
        rs1_data_i    = 32'd0;
        commit_id_i   = 4'd0;
        int_assert_i  = 1'b0;
        wb_ready_i    = 1'b0;
        for (cycle = 0; cycle < 8; cycle++)
            model_csr[cycle] = 32'd0;
        exp_rd_we     = 1'b0;
        exp_csr_we    = 1'b0;
        exp_rd_addr   = 5'd0;
        exp_rd_wdata  = 32'd0;
        exp_csr_wdata = 32'd0;
        exp_csr_waddr = 12'd0;
        exp_commit_id = 4'd0;

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        check_outputs();                     // reset state, all zero

        // csrrs rd=x1, rs1=x0 on each CSR, everything reads zero
        for (cycle = 0; cycle < DIRECTED_CYCLES; cycle++) begin
            model_edge();
            drive_inputs(1'b1, {pick_csr(cycle[2:0]), 5'd0, 3'b010, 5'd1, OPC_SYSTEM},
                         32'hFFFF_FFFF, 1'b0, 1'b1);
            @(negedge clk);
            check_outputs();
        end

        for (cycle = 0; cycle < RANDOM_CYCLES; cycle++) begin
            model_edge();
            drive_random();
            @(negedge clk);
            check_outputs();
        end

        // drain the last issued instruction
        model_edge();
        drive_inputs(1'b0, 32'd0, 32'd0, 1'b0, 1'b1);
        @(negedge clk);
        check_outputs();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
